/* Makefile */
TOOL       = verilator
TOP        = tb_top
FLIST      = vlog.f
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# Simulator exit code is ignored, the log decides
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/act_feeder.sv */
`timescale 1ns/1ps
`default_nettype none

module act_feeder
    import sa_pkg::*;
#(
    parameter  int K      = K_DEF,
    parameter  int COLS   = 4,
    localparam int CIDX_W = $clog2(COLS + 1)    // Room for out-of-range index
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              in_valid,
    input  lane_t [K-1:0]     in_act,
    input  logic              wt_we,
    input  logic [CIDX_W-1:0] wt_col,
    input  wt_wr_t            wt_wr,
    output act_beat_t         beat_q,
    output logic [COLS-1:0]   col_we,
    output wt_wr_t            wt_q
);

    act_beat_t       beat_d;
    logic [COLS-1:0] we_dec;

    // Lanes above K stay zero
    always_comb begin
        beat_d       = '0;
        beat_d.valid = in_valid;
        for (int k = 0; k < K; k++) begin
            beat_d.lanes[k] = in_act[k];
        end
    end

    // One-hot column strobe
    always_comb begin
        we_dec = '0;
        for (int c = 0; c < COLS; c++) begin
            if (wt_we && wt_col == CIDX_W'(c)) begin
                we_dec[c] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_q <= '0;
            col_we <= '0;
            wt_q   <= '0;
        end else begin
            beat_q <= beat_d;
            col_we <= we_dec;
            if (wt_we) begin
                wt_q <= wt_wr;          // Hold last payload otherwise
            end
        end
    end

endmodule

`default_nettype wire

/* hw/mac_column.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_column
    import sa_pkg::*;
#(
    parameter int K = K_DEF
) (
    input  logic          clk,
    input  logic          rstn,
    input  lane_t [K-1:0] sk_lanes,
    input  logic          sk_valid,
    input  logic          wt_we,
    input  wt_wr_t        wt_wr,
    output acc_t          res_col,
    output logic          col_valid
);

    lane_t       wt   [K];      // Stationary weights
    prod_t       prod [K];
    acc_t        psum [K];      // Partial sum leaving cell k
    logic [K-1:0] vld;

    // Weight load by lane index
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int k = 0; k < K; k++) begin
                wt[k] <= '0;
            end
        end else if (wt_we) begin
            for (int k = 0; k < K; k++) begin
                if (wt_wr.idx == lidx_t'(k)) begin
                    wt[k] <= wt_wr.data;
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < K; k++) begin
            prod[k] = wt[k] * $signed(sk_lanes[k]);
        end
    end

    // Sum moves one cell per cycle, skewed lane k arrives just in time
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int k = 0; k < K; k++) begin
                psum[k] <= '0;
            end
            vld <= '0;
        end else begin
            psum[0] <= acc_t'(prod[0]);
            vld[0]  <= sk_valid;
            for (int k = 1; k < K; k++) begin
                psum[k] <= psum[k-1] + acc_t'(prod[k]);
                vld[k]  <= vld[k-1];
            end
        end
    end

    assign res_col   = psum[K-1];
    assign col_valid = vld[K-1];

endmodule

`default_nettype wire

/* hw/sa_pkg.sv */
`default_nettype none

package sa_pkg;

    // Fixed byte width of activations and weights
    localparam int DATA_W = 8;

    // Default lane count, modules take K as a parameter
    localparam int K_DEF = 9;

    // Lane index field in a weight write
    localparam int LIDX_W = 4;

    localparam int PROD_W = 2 * DATA_W;                 // Full int8 x int8 product
    localparam int ACC_W  = PROD_W + $clog2(K_DEF);     // 16 product bits + 4 headroom

    typedef logic signed [DATA_W-1:0] lane_t;
    typedef logic        [LIDX_W-1:0] lidx_t;
    typedef logic signed [PROD_W-1:0] prod_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // One activation vector with its strobe
    typedef struct packed {
        logic                    valid;
        lane_t [K_DEF-1:0]       lanes;
    } act_beat_t;

    // Weight write payload, column comes separately
    typedef struct packed {
        lidx_t                   idx;   // Lane within the column
        lane_t                   data;
    } wt_wr_t;

endpackage

`default_nettype wire

/* hw/sa_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sa_top
    import sa_pkg::*;
#(
    parameter  int K      = K_DEF,
    parameter  int COLS   = 4,
    localparam int CIDX_W = $clog2(COLS + 1)
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              in_valid,
    input  lane_t [K-1:0]     in_act,
    input  logic              wt_we,
    input  logic [CIDX_W-1:0] wt_col,
    input  wt_wr_t            wt_wr,
    output logic              res_valid,
    output acc_t [COLS-1:0]   res
);

    act_beat_t       beat_q;
    logic [COLS-1:0] col_we;
    wt_wr_t          wt_q;
    lane_t [K-1:0]   sk_lanes;
    logic            sk_valid;
    logic [COLS-1:0] col_valid;

    // Beat struct and lane index field bound the lane count
    if (K > K_DEF || K > 2 ** LIDX_W) begin : g_bad_k
        $error("K exceeds beat or lane index capacity");
    end

    act_feeder #(
        .K    (K),
        .COLS (COLS)
    ) i_feeder (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .in_act   (in_act),
        .wt_we    (wt_we),
        .wt_col   (wt_col),
        .wt_wr    (wt_wr),
        .beat_q   (beat_q),
        .col_we   (col_we),
        .wt_q     (wt_q)
    );

    // Single skew, broadcast to all columns
    skew_align #(
        .K (K)
    ) i_skew (
        .clk      (clk),
        .rstn     (rstn),
        .beat     (beat_q),
        .sk_lanes (sk_lanes),
        .sk_valid (sk_valid)
    );

    for (genvar c = 0; c < COLS; c++) begin : g_col
        mac_column #(
            .K (K)
        ) i_col (
            .clk       (clk),
            .rstn      (rstn),
            .sk_lanes  (sk_lanes),
            .sk_valid  (sk_valid),
            .wt_we     (col_we[c]),
            .wt_wr     (wt_q),
            .res_col   (res[c]),
            .col_valid (col_valid[c])
        );
    end

    assign res_valid = col_valid[0];    // All columns share timing

endmodule

`default_nettype wire

/* hw/skew_align.sv */
`timescale 1ns/1ps
`default_nettype none

module skew_align
    import sa_pkg::*;
#(
    parameter int K = K_DEF
) (
    input  logic          clk,
    input  logic          rstn,
    input  act_beat_t     beat,
    output lane_t [K-1:0] sk_lanes,
    output logic          sk_valid
);

    // Lane 0 and the strobe meet cell 0 directly
    assign sk_lanes[0] = beat.lanes[0];
    assign sk_valid    = beat.valid;

    // Lane k gets a k-deep shift chain, so the chains form a triangle
    for (genvar k = 1; k < K; k++) begin : g_lane
        lane_t [k-1:0] sr;

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                sr <= '0;
            end else begin
                sr[0] <= beat.lanes[k];
                for (int s = 1; s < k; s++) begin
                    sr[s] <= sr[s-1];
                end
            end
        end

        assign sk_lanes[k] = sr[k-1];   // Oldest stage
    end

endmodule

`default_nettype wire

/* tb/sa_top_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module sa_top_sva
    import sa_pkg::*;
#(
    parameter int K    = K_DEF,
    parameter int COLS = 4
) (
    input logic            clk,
    input logic            rstn,
    input logic            in_valid,
    input logic            res_valid,
    input acc_t [COLS-1:0] res
);

    int sva_errs = 0;   // Assertion failures so far

    // No result may leave the array while reset is held
    a_reset_quiet : assert property (
        @(posedge clk) !rstn |-> !res_valid
    ) else begin
        sva_errs++;
        $error("res_valid high during reset");
    end

    // One feeder stage and one register per cell
    a_latency : assert property (
        @(posedge clk) disable iff (!rstn)
        res_valid == $past(in_valid, K + 1)
    ) else begin
        sva_errs++;
        $error("res_valid does not follow in_valid by K+1 edges");
    end

    a_valid_known : assert property (
        @(posedge clk) disable iff (!rstn)
        !$isunknown(res_valid)
    ) else begin
        sva_errs++;
        $error("res_valid is unknown");
    end

    a_res_known : assert property (
        @(posedge clk) disable iff (!rstn)
        res_valid |-> !$isunknown(res)
    ) else begin
        sva_errs++;
        $error("res carries unknown bits while valid");
    end

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release just after the last reset edge
    initial begin
        rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import sa_pkg::*;
;

    localparam int K       = K_DEF;
    localparam int COLS    = 4;
    localparam int CIDX_W  = $clog2(COLS + 1);
    localparam int N_BURST = 40;
    localparam int N_GAP   = 20;
    localparam int MAX_GAP = 6;
    localparam int WR_ALL  = COLS * K + 1;
    localparam int DRAIN   = K + 7;
    localparam int STIM_CYCLES = 6 + (WR_ALL + 4 + DRAIN) + (WR_ALL + N_BURST + DRAIN)
                               + (N_GAP * (MAX_GAP + 1) + DRAIN) + (WR_ALL + 2 + DRAIN)
                               + (6 + DRAIN) + (7 + DRAIN);
    localparam int TIMEOUT = 2 * STIM_CYCLES + 100;

    typedef lane_t [K-1:0] vec_t;

    logic              clk;
    logic              rstn;
    logic              in_valid;
    vec_t              in_act;
    logic              wt_we;
    logic [CIDX_W-1:0] wt_col;
    wt_wr_t            wt_wr;
    logic              res_valid;
    acc_t [COLS-1:0]   res;

    int wts [COLS][K];      // Model copy of the stationary weights
    int exp_q [$];          // COLS entries per beat
    int val_errs   = 0;
    int other_errs = 0;
    int cycles     = 0;

    tb_clkgen #(.PERIOD_NS(10), .RST_CYCLES(4)) i_clkgen (.clk(clk), .rstn(rstn));

    sa_top #(.K(K), .COLS(COLS)) i_dut (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .in_act    (in_act),
        .wt_we     (wt_we),
        .wt_col    (wt_col),
        .wt_wr     (wt_wr),
        .res_valid (res_valid),
        .res       (res)
    );

    bind sa_top sa_top_sva #(.K(K), .COLS(COLS)) i_sva (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .res_valid (res_valid),
        .res       (res)
    );

    function automatic int dot(input int c, input vec_t a);
        int sum;
        sum = 0;
        for (int k = 0; k < K; k++) begin
            sum += wts[c][k] * int'(a[k]);
        end
        return sum;
    endfunction

    function automatic vec_t fill_lanes(input lane_t v);
        vec_t a;
        for (int k = 0; k < K; k++) begin
            a[k] = v;
        end
        return a;
    endfunction

    function automatic vec_t rand_lanes();
        vec_t a;
        for (int k = 0; k < K; k++) begin
            a[k] = lane_t'($urandom());
        end
        return a;
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            wt_we    = 1'b0;
        end
    endtask

    task automatic send_beat(input vec_t a);
        @(posedge clk);
        #1;
        wt_we    = 1'b0;
        in_valid = 1'b1;
        in_act   = a;
        for (int c = 0; c < COLS; c++) begin
            exp_q.push_back(dot(c, a));
        end
    endtask

    task automatic write_weight(input int col, input int lane, input lane_t data);
        @(posedge clk);
        #1;
        in_valid   = 1'b0;
        wt_we      = 1'b1;
        wt_col     = CIDX_W'(col);
        wt_wr.idx  = lidx_t'(lane);
        wt_wr.data = data;
        if (col < COLS) begin
            wts[col][lane] = int'(data);    // Out-of-range column is dropped
        end
    endtask

    // Bounded wait until every pending result came out
    task automatic drain();
        idle(1);
        for (int i = 0; i < K + 4 && exp_q.size() != 0; i++) begin
            @(posedge clk);
        end
        idle(2);
    endtask

    always @(negedge clk) begin : check_results
        int exp_v;
        int got_v;
        if (rstn && res_valid) begin
            if (exp_q.size() < COLS) begin
                other_errs++;
                $display("Error at %0t: result presented with no beat pending", $time);
            end else begin
                for (int c = 0; c < COLS; c++) begin
                    exp_v = exp_q.pop_front();
                    got_v = int'($signed(res[c]));
                    assert (got_v == exp_v) else begin
                        val_errs++;
                        $display("Fail at %0t: res[%0d] expected %0d got %0d",
                                 $time, c, exp_v, got_v);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h2de83d4a));
        in_valid = 1'b0;
        in_act   = '0;
        wt_we    = 1'b0;
        wt_col   = '0;
        wt_wr    = '0;
        for (int c = 0; c < COLS; c++) begin
            for (int k = 0; k < K; k++) begin
                wts[c][k] = 0;              // DUT weights clear on reset
            end
        end
        @(posedge rstn);
        idle(2);

        // Identity weights so res[c] shows lane c
        for (int c = 0; c < COLS; c++) begin
            for (int k = 0; k < K; k++) begin
                write_weight(c, k, (k == c) ? lane_t'(1) : lane_t'(0));
            end
        end
        idle(1);
        repeat (4) send_beat(rand_lanes());
        drain();

        // Back-to-back burst with K+1 beats in flight
        for (int c = 0; c < COLS; c++) begin
            for (int k = 0; k < K; k++) begin
                write_weight(c, k, lane_t'($urandom()));
            end
        end
        idle(1);
        repeat (N_BURST) send_beat(rand_lanes());
        drain();

        for (int i = 0; i < N_GAP; i++) begin
            send_beat(rand_lanes());
            idle(int'($urandom_range(0, MAX_GAP)));
        end
        drain();

        // Accumulator extremes
        for (int c = 0; c < COLS; c++) begin
            for (int k = 0; k < K; k++) begin
                write_weight(c, k, lane_t'(-128));
            end
        end
        idle(1);
        send_beat(fill_lanes(lane_t'(-128)));   // 147456
        send_beat(fill_lanes(lane_t'(127)));    // -146304
        drain();

        write_weight(1, 3, lane_t'(77));
        idle(2);
        repeat (3) send_beat(rand_lanes());
        drain();

        // Column index past the array
        write_weight(COLS, 2, lane_t'(-5));
        write_weight((1 << CIDX_W) - 1, 0, lane_t'(99));
        idle(2);
        repeat (3) send_beat(rand_lanes());
        drain();

        assert (exp_q.size() == 0) else begin
            other_errs++;
            $display("Error: %0d expected results never came out", exp_q.size() / COLS);
        end
        $display("Errors: %0d value mismatches, %0d assertion failures, %0d other",
                 val_errs, i_dut.i_sva.sva_errs, other_errs);
        if (val_errs + other_errs + i_dut.i_sva.sva_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/sa_pkg.sv
hw/act_feeder.sv
hw/skew_align.sv
hw/mac_column.sv
hw/sa_top.sv
tb/tb_clkgen.sv
tb/sa_top_sva.sv
tb/tb_top.sv
